// File: source/pmpPkg.sv
/*
  Shared constants for the PMP unit.
  The register map is fixed at 8 regions and a 32-bit physical address.
  Address registers hold physical address bits 31..2, zero-extended.
*/
package pmpPkg;

  // Sizes
  localparam int numRegions   = 8;
  localparam int addrWidth    = 32;
  localparam int apbAddrWidth = 8;
  localparam int counterWidth = 16;

  // Bit positions inside one config byte
  localparam int cfgBitR   = 0;
  localparam int cfgBitW   = 1;
  localparam int cfgBitX   = 2;
  localparam int cfgBitALo = 3;
  localparam int cfgBitL   = 7;

  // Address matching modes held in the A field
  localparam logic [1:0] modeOff   = 2'd0;
  localparam logic [1:0] modeTor   = 2'd1;
  localparam logic [1:0] modeNa4   = 2'd2;
  localparam logic [1:0] modeNapot = 2'd3;

  // Privilege levels, with 2 reserved
  localparam logic [1:0] privU = 2'd0;
  localparam logic [1:0] privS = 2'd1;
  localparam logic [1:0] privM = 2'd3;

  // Kind of access presented on the check port
  localparam logic [1:0] accNone  = 2'd0;
  localparam logic [1:0] accFetch = 2'd1;
  localparam logic [1:0] accLoad  = 2'd2;
  localparam logic [1:0] accStore = 2'd3;

  // APB register map, byte addresses
  localparam logic [apbAddrWidth-1:0] regCfg0       = 8'h00;
  localparam logic [apbAddrWidth-1:0] regCfg1       = 8'h04;
  localparam logic [apbAddrWidth-1:0] regAddrBase   = 8'h10;
  localparam logic [apbAddrWidth-1:0] regAddrLast   =
    regAddrBase + apbAddrWidth'(4 * (numRegions - 1));
  localparam logic [apbAddrWidth-1:0] regFaultCount = 8'h30;

  // APB phase encodings for the slave FSM
  localparam logic [1:0] apbIdle   = 2'd0;
  localparam logic [1:0] apbSetup  = 2'd1;
  localparam logic [1:0] apbAccess = 2'd2;

endpackage

// File: source/apbSlaveFsm.sv
/*
  APB3 slave phase tracker with zero wait states.
  Outputs follow the current bus phase combinationally.
  Unmapped or unaligned addresses complete with PSLVERR and no strobe.
*/
`timescale 1ns/1ps

module apbSlaveFsm (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             PSEL,
  input  logic                             PENABLE,
  input  logic                             PWRITE,
  input  logic [pmpPkg::apbAddrWidth-1:0]  PADDR,
  output logic                             PREADY,
  output logic                             PSLVERR,
  output logic                             regWrite,
  output logic                             regRead
);
  import pmpPkg::*;

  // The register holds the phase of the previous cycle
  logic [1:0] phaseQ;
  logic [1:0] phase;
  logic       aligned;
  logic       mapped;
  logic       inAccess;

  ////////////////////////////////////////
  // Phase sequencing
  ////////////////////////////////////////

  // An access phase only counts when it directly follows a setup phase
  always_comb begin
    phase = apbIdle;
    case (phaseQ)
      apbSetup: begin
        if (PSEL && PENABLE) begin
          phase = apbAccess;
        end else if (PSEL) begin
          // Setup seen again, so the transfer restarts
          phase = apbSetup;
        end
      end
      apbIdle, apbAccess: begin
        if (PSEL && !PENABLE) begin
          phase = apbSetup;
        end
      end
      default: phase = apbIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phaseQ <= apbIdle;
    end else begin
      phaseQ <= phase;
    end
  end

  ////////////////////////////////////////
  // Address decode and strobes
  ////////////////////////////////////////

  assign aligned = (PADDR[1:0] == 2'b00);

  // Config words, the address block and the counter form the whole map
  assign mapped = aligned && ((PADDR == regCfg0) || (PADDR == regCfg1) ||
                  ((PADDR >= regAddrBase) && (PADDR <= regAddrLast)) ||
                  (PADDR == regFaultCount));

  assign inAccess = (phase == apbAccess);
  assign PREADY   = inAccess;
  assign PSLVERR  = inAccess && !mapped;
  assign regWrite = inAccess && mapped && PWRITE;
  assign regRead  = inAccess && mapped && !PWRITE;

endmodule

// File: source/pmpRegFile.sv
/*
  PMP config bytes and address registers behind the APB map.
  Locked bytes and locked addresses ignore writes until reset.
  A locked TOR entry also protects the address register below it.
  Writing the counter address clears the fault count and stores nothing.
*/
`timescale 1ns/1ps

module pmpRegFile (
  input  logic                                                clk,
  input  logic                                                reset,
  input  logic                                                regWrite,
  input  logic                                                regRead,
  input  logic [pmpPkg::apbAddrWidth-1:0]                     PADDR,
  input  logic [31:0]                                         PWDATA,
  input  logic [pmpPkg::counterWidth-1:0]                     faultCount,
  output logic [31:0]                                         PRDATA,
  output logic [pmpPkg::numRegions-1:0][7:0]                  cfgFlat,
  output logic [pmpPkg::numRegions-1:0][pmpPkg::addrWidth-1:0] addrFlat,
  output logic                                                faultClear
);
  import pmpPkg::*;

  logic [numRegions-1:0][7:0]           cfgQ;
  logic [numRegions-1:0][addrWidth-1:0] addrQ;
  logic [numRegions-1:0]                cfgWrEn;
  logic [numRegions-1:0]                addrWrEn;
  // Set when the entry above is a locked TOR entry
  logic [numRegions-1:0]                torLockAbove;
  logic [31:0]                          readData;

  ////////////////////////////////////////
  // Lock-aware write enables
  ////////////////////////////////////////

  for (genvar r = 0; r < numRegions; r++) begin : genWrEn
    // Lower half of the regions lives in cfg0, upper half in cfg1
    assign cfgWrEn[r] = regWrite && !cfgQ[r][cfgBitL] &&
                        ((r < numRegions / 2) ? (PADDR == regCfg0) : (PADDR == regCfg1));

    if (r < numRegions - 1) begin : genNext
      assign torLockAbove[r] = cfgQ[r+1][cfgBitL] &&
                               (cfgQ[r+1][cfgBitALo +: 2] == modeTor);
    end else begin : genTop
      assign torLockAbove[r] = 1'b0;
    end

    assign addrWrEn[r] = regWrite && !cfgQ[r][cfgBitL] && !torLockAbove[r] &&
                         (PADDR == regAddrBase + apbAddrWidth'(4 * r));
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cfgQ  <= '0;
      addrQ <= '0;
    end else begin
      for (int r = 0; r < numRegions; r++) begin
        // Each region takes its own byte lane of the word
        if (cfgWrEn[r]) begin
          cfgQ[r] <= PWDATA[8*(r % 4) +: 8];
        end
        // Only bits 31..2 of the address are kept
        if (addrWrEn[r]) begin
          addrQ[r] <= {2'b00, PWDATA[addrWidth-3:0]};
        end
      end
    end
  end

  assign cfgFlat    = cfgQ;
  assign addrFlat   = addrQ;
  assign faultClear = regWrite && (PADDR == regFaultCount);

  ////////////////////////////////////////
  // Read data
  ////////////////////////////////////////

  always_comb begin
    readData = '0;
    if (PADDR == regCfg0) begin
      readData = cfgQ[3:0];
    end else if (PADDR == regCfg1) begin
      readData = cfgQ[7:4];
    end else if (PADDR == regFaultCount) begin
      readData = {{(32 - counterWidth){1'b0}}, faultCount};
    end
    for (int r = 0; r < numRegions; r++) begin
      if (PADDR == regAddrBase + apbAddrWidth'(4 * r)) begin
        readData = addrQ[r];
      end
    end
  end

  // The bus sees data only during a mapped read
  assign PRDATA = regRead ? readData : '0;

endmodule

// File: source/pmpAdrDec.sv
/*
  Address matcher for one PMP region.
  curAddr carries physical address bits 31..2, so matching is per word.
  NAPOT regions are at least 8 bytes, NA4 exactly one word.
*/
`timescale 1ns/1ps

module pmpAdrDec (
  input  logic [pmpPkg::addrWidth-1:0] accAddr,
  input  logic [1:0]                   adrMode,
  input  logic [pmpPkg::addrWidth-1:0] curAddr,
  input  logic                         atLeastPrev,
  output logic                         atLeastCur,
  output logic                         match
);
  import pmpPkg::*;

  logic [addrWidth-3:0] accWord;
  logic [addrWidth-3:0] curWord;
  // Bits of the word address that a NAPOT region ignores
  logic [addrWidth-3:0] napotDontCare;
  logic                 torHit;
  logic                 na4Hit;
  logic                 napotHit;

  assign accWord = accAddr[addrWidth-1:2];
  assign curWord = curAddr[addrWidth-3:0];

  // Feeds the next region as the bottom of its TOR range
  assign atLeastCur = (accWord >= curWord);

  // TOR covers prevAddr <= addr < curAddr
  assign torHit = atLeastPrev && !atLeastCur;

  assign na4Hit = (accWord == curWord);

  // Adding one flips the trailing ones and the first zero above them,
  // which is exactly the span a NAPOT encoding leaves open
  assign napotDontCare = curWord ^ (curWord + 1'b1);
  assign napotHit      = (((accWord ^ curWord) & ~napotDontCare) == '0);

  always_comb begin
    case (adrMode)
      modeTor:   match = torHit;
      modeNa4:   match = na4Hit;
      modeNapot: match = napotHit;
      modeOff:   match = 1'b0;
      default:   match = 1'b0;
    endcase
  end

endmodule

// File: source/pmpChecker.sv
/*
  Combinational PMP check of one access against all regions.
  The lowest-numbered matching region decides.
  S and U mode are denied by default once any region is active,
  M mode is only restricted by locked regions.
*/
`timescale 1ns/1ps

module pmpChecker (
  input  logic [1:0]                                          accKind,
  input  logic [pmpPkg::addrWidth-1:0]                        accAddr,
  input  logic [1:0]                                          accPriv,
  input  logic [pmpPkg::numRegions-1:0][7:0]                  cfgFlat,
  input  logic [pmpPkg::numRegions-1:0][pmpPkg::addrWidth-1:0] addrFlat,
  output logic                                                instrFault,
  output logic                                                loadFault,
  output logic                                                storeFault,
  output logic                                                squash
);
  import pmpPkg::*;

  // Bit r+1 is high when the access is at or above region r's address
  logic [numRegions:0]   atLeastChain;
  logic [numRegions-1:0] regionHit;
  logic [numRegions-1:0] regionActive;
  logic [7:0]            hitCfg;
  logic                  anyHit;
  logic                  lBit, xBit, wBit, rBit;
  logic                  isFetch, isLoad, isStore;
  logic                  enforce;

  ////////////////////////////////////////
  // Region decoders
  ////////////////////////////////////////

  // Region 0 in TOR mode starts at address zero
  assign atLeastChain[0] = 1'b1;

  for (genvar r = 0; r < numRegions; r++) begin : genDec
    pmpAdrDec decI (
      .accAddr     (accAddr),
      .adrMode     (cfgFlat[r][cfgBitALo +: 2]),
      .curAddr     (addrFlat[r]),
      .atLeastPrev (atLeastChain[r]),
      .atLeastCur  (atLeastChain[r+1]),
      .match       (regionHit[r])
    );
    assign regionActive[r] = (cfgFlat[r][cfgBitALo +: 2] != modeOff);
  end

  // Walk from the top so the lowest hit is written last
  always_comb begin
    hitCfg = '0;
    for (int r = numRegions - 1; r >= 0; r--) begin
      if (regionHit[r]) begin
        hitCfg = cfgFlat[r];
      end
    end
  end

  assign anyHit = |regionHit;
  // Without a hit every permission reads as missing
  assign lBit = anyHit && hitCfg[cfgBitL];
  assign xBit = anyHit && hitCfg[cfgBitX];
  assign wBit = anyHit && hitCfg[cfgBitW];
  assign rBit = anyHit && hitCfg[cfgBitR];

  ////////////////////////////////////////
  // Fault decision
  ////////////////////////////////////////

  always_comb begin
    isFetch = 1'b0;
    isLoad  = 1'b0;
    isStore = 1'b0;
    case (accKind)
      accFetch: isFetch = 1'b1;
      accLoad:  isLoad  = 1'b1;
      accStore: isStore = 1'b1;
      accNone:  isFetch = 1'b0;
      default:  isFetch = 1'b0;
    endcase
  end

  // Reserved privilege 2 is checked like U mode
  always_comb begin
    case (accPriv)
      privM:        enforce = lBit;
      privS, privU: enforce = |regionActive;
      default:      enforce = |regionActive;
    endcase
  end

  assign instrFault = enforce && isFetch && !xBit;
  assign loadFault  = enforce && isLoad  && !rBit;
  assign storeFault = enforce && isStore && !wBit;
  assign squash     = instrFault || loadFault || storeFault;

endmodule

// File: source/faultCounter.sv
/*
  Counts cycles in which the checker squashed an access.
  Holds at all ones instead of wrapping.
  A software clear wins over an increment in the same cycle.
*/
`timescale 1ns/1ps

module faultCounter (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            squash,
  input  logic                            faultClear,
  output logic [pmpPkg::counterWidth-1:0] faultCount
);
  import pmpPkg::*;

  logic [counterWidth-1:0] countQ;
  logic                    saturated;

  assign saturated = &countQ;

  always_ff @(posedge clk) begin
    if (reset) begin
      countQ <= '0;
    end else if (faultClear) begin
      countQ <= '0;
    end else if (squash && !saturated) begin
      countQ <= countQ + 1'b1;
    end
  end

  assign faultCount = countQ;

endmodule

// File: source/pmpUnit.sv
/*
  PMP unit top with an APB3 config port and a combinational check port.
  8 regions, 32-bit physical addresses, no wait states on APB.
  Fault outputs follow the access inputs in the same cycle.
*/
`timescale 1ns/1ps

module pmpUnit (
  input  logic                            clk,
  input  logic                            reset,
  // APB3 slave port
  input  logic                            PSEL,
  input  logic                            PENABLE,
  input  logic                            PWRITE,
  input  logic [pmpPkg::apbAddrWidth-1:0] PADDR,
  input  logic [31:0]                     PWDATA,
  output logic [31:0]                     PRDATA,
  output logic                            PREADY,
  output logic                            PSLVERR,
  // Access check port
  input  logic [1:0]                      accKind,
  input  logic [pmpPkg::addrWidth-1:0]    accAddr,
  input  logic [1:0]                      accPriv,
  output logic                            instrFault,
  output logic                            loadFault,
  output logic                            storeFault,
  output logic                            squash
);
  import pmpPkg::*;

  logic                                 regWrite;
  logic                                 regRead;
  logic                                 faultClear;
  logic [counterWidth-1:0]              faultCount;
  logic [numRegions-1:0][7:0]           cfgFlat;
  logic [numRegions-1:0][addrWidth-1:0] addrFlat;

  apbSlaveFsm apbI (
    .clk(clk), .reset(reset), .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
    .PADDR(PADDR), .PREADY(PREADY), .PSLVERR(PSLVERR),
    .regWrite(regWrite), .regRead(regRead)
  );

  pmpRegFile regI (
    .clk(clk), .reset(reset), .regWrite(regWrite), .regRead(regRead),
    .PADDR(PADDR), .PWDATA(PWDATA), .faultCount(faultCount), .PRDATA(PRDATA),
    .cfgFlat(cfgFlat), .addrFlat(addrFlat), .faultClear(faultClear)
  );

  pmpChecker checkI (
    .accKind(accKind), .accAddr(accAddr), .accPriv(accPriv),
    .cfgFlat(cfgFlat), .addrFlat(addrFlat),
    .instrFault(instrFault), .loadFault(loadFault), .storeFault(storeFault),
    .squash(squash)
  );

  // Squashed cycles are counted for software to read back
  faultCounter countI (
    .clk(clk), .reset(reset), .squash(squash), .faultClear(faultClear),
    .faultCount(faultCount)
  );

endmodule

// File: include/pmpTbModel.svh
/*
  Reference model of the PMP check, included inside the testbench module.
  Reads shadowCfg, shadowAddr, shadowCount and lcgState of the includer.
  Only privilege levels U, S and M are modelled.
*/
`ifndef PMP_TB_MODEL_SVH
`define PMP_TB_MODEL_SVH

// Linear congruential generator with the usual C library constants
function automatic logic [15:0] lcgNext();
  lcgState = lcgState * 32'd1103515245 + 32'd12345;
  return lcgState[30:15];
endfunction

// True when the APB byte address hits a register of the map
function automatic logic mappedAddr(input logic [7:0] a);
  logic inAddrBlock;
  inAddrBlock = (a >= regAddrBase) && (a <= regAddrBase + 8'(4 * (numRegions - 1)));
  return (a[1:0] == 2'b00) &&
         ((a == regCfg0) || (a == regCfg1) || inAddrBlock || (a == regFaultCount));
endfunction

// Does region r cover the byte address, judged on word addresses
function automatic logic regionMatch(input int r, input logic [31:0] addr);
  logic [31:0] word;
  logic [31:0] lower;
  logic [31:0] upper;
  int          ones;
  word  = {2'b00, addr[31:2]};
  upper = shadowAddr[r];
  lower = (r == 0) ? 32'd0 : shadowAddr[r-1];
  ones  = 0;
  // NAPOT size is twice the span of the trailing ones
  while ((ones < 30) && upper[ones]) begin
    ones++;
  end
  case (shadowCfg[r][cfgBitALo +: 2])
    modeTor:   return (word >= lower) && (word < upper);
    modeNa4:   return word == upper;
    modeNapot: return (word >> (ones + 1)) == (upper >> (ones + 1));
    default:   return 1'b0;
  endcase
endfunction

// Expected {instrFault, loadFault, storeFault} for one access
function automatic logic [2:0] expectFault(input logic [31:0] addr, input logic [1:0] kind,
                                           input logic [1:0] priv);
  logic [7:0] cfg;
  logic       hit;
  logic       active;
  logic       enforce;
  cfg    = '0;
  hit    = 1'b0;
  active = 1'b0;
  // The first matching region wins
  for (int r = 0; r < numRegions; r++) begin
    if (shadowCfg[r][cfgBitALo +: 2] != modeOff) begin
      active = 1'b1;
    end
    if (!hit && regionMatch(r, addr)) begin
      hit = 1'b1;
      cfg = shadowCfg[r];
    end
  end
  // M mode only obeys locked regions, S and U are denied by default
  enforce = (priv == privM) ? (hit && cfg[cfgBitL]) : active;
  return {enforce && (kind == accFetch) && !(hit && cfg[cfgBitX]),
          enforce && (kind == accLoad) && !(hit && cfg[cfgBitR]),
          enforce && (kind == accStore) && !(hit && cfg[cfgBitW])};
endfunction

// Register contents that a read of address a returns
function automatic logic [31:0] shadowRead(input logic [7:0] a);
  logic [31:0] data;
  data = '0;
  if (a == regCfg0) begin
    data = {shadowCfg[3], shadowCfg[2], shadowCfg[1], shadowCfg[0]};
  end else if (a == regCfg1) begin
    data = {shadowCfg[7], shadowCfg[6], shadowCfg[5], shadowCfg[4]};
  end else if (a == regFaultCount) begin
    data = 32'(shadowCount);
  end
  for (int r = 0; r < numRegions; r++) begin
    if (a == regAddrBase + 8'(4 * r)) begin
      data = shadowAddr[r];
    end
  end
  return data;
endfunction

`endif

// File: tests/pmpUnitTb.sv
/*
  Self-checking testbench for the PMP unit.
  Inputs change on the falling edge and checks run on the rising edge.
  APB transfers are two cycles with no wait states.
*/
`timescale 1ns/1ps

module pmpUnitTb;
  import pmpPkg::*;

  // About 1000 cycles of tests, planned with a threefold margin
  localparam int plannedCycles = 3000;
  localparam int timeoutCycles = 2 * plannedCycles;

  logic clk = 1'b0;
  logic reset, PSEL, PENABLE, PWRITE, PREADY, PSLVERR;
  logic [7:0] PADDR;
  logic [31:0] PWDATA, PRDATA, accAddr;
  logic [1:0] accKind, accPriv;
  logic instrFault, loadFault, storeFault, squash;

  // Shadow copy of the registers, used by the reference model
  logic [7:0] shadowCfg [numRegions];
  logic [31:0] shadowAddr [numRegions];
  logic [counterWidth-1:0] shadowCount;
  logic [31:0] lcgState;
  // Error counts for fault outputs, read data and bus handshake
  int errCount [3];
  int cycleCount;

  `include "pmpTbModel.svh"

  pmpUnit dut_i (.*);

  initial begin
    forever #20 clk = ~clk;
  end

  task automatic checkValue(input string sigName, input logic [31:0] expVal,
                            input logic [31:0] actVal, input int kind);
    assert (actVal === expVal) else begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, sigName, expVal, actVal);
      errCount[kind]++;
    end
  endtask

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  always @(posedge clk) begin : compare
    logic [2:0] expF;
    logic       inAccess;
    if (reset) begin
      shadowCount = '0;
    end else begin
      expF = expectFault(accAddr, accKind, accPriv);
      checkValue("instrFault", 32'(expF[2]), 32'(instrFault), 0);
      checkValue("loadFault", 32'(expF[1]), 32'(loadFault), 0);
      checkValue("storeFault", 32'(expF[0]), 32'(storeFault), 0);
      checkValue("squash", 32'(|expF), 32'(squash), 0);
      inAccess = PSEL && PENABLE;
      checkValue("PREADY", 32'(inAccess), 32'(PREADY), 2);
      checkValue("PSLVERR", 32'(inAccess && !mappedAddr(PADDR)), 32'(PSLVERR), 2);
      if (inAccess && !PWRITE && mappedAddr(PADDR)) begin
        checkValue("PRDATA", shadowRead(PADDR), PRDATA, 1);
      end
      // A clear on the same edge beats the increment
      if (inAccess && PWRITE && (PADDR == regFaultCount)) begin
        shadowCount = '0;
      end else if ((|expF) && (shadowCount != '1)) begin
        shadowCount++;
      end
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Bus and access tasks
  ////////////////////////////////////////

  // Mirrors a completed write into the shadow with the lock rules
  task automatic applyWrite(input logic [7:0] a, input logic [31:0] d);
    logic torLockAbove;
    for (int r = 0; r < numRegions; r++) begin
      torLockAbove = (r < numRegions - 1) && shadowCfg[r+1][cfgBitL] &&
                     (shadowCfg[r+1][cfgBitALo +: 2] == modeTor);
      if (!shadowCfg[r][cfgBitL] && (a == ((r < 4) ? regCfg0 : regCfg1))) begin
        shadowCfg[r] = d[8*(r % 4) +: 8];
      end
      if (!shadowCfg[r][cfgBitL] && !torLockAbove && (a == regAddrBase + 8'(4 * r))) begin
        shadowAddr[r] = {2'b00, d[29:0]};
      end
    end
  endtask

  task automatic apbWrite(input logic [7:0] a, input logic [31:0] d);
    @(negedge clk);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b1;
    PADDR   = a;
    PWDATA  = d;
    @(negedge clk);
    PENABLE = 1'b1;
    @(negedge clk);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    applyWrite(a, d);
  endtask

  task automatic apbRead(input logic [7:0] a, output logic [31:0] data);
    @(negedge clk);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = a;
    @(negedge clk);
    PENABLE = 1'b1;
    @(posedge clk);
    data = PRDATA;
    @(negedge clk);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic readExpect(input logic [7:0] a, input logic [31:0] expData);
    logic [31:0] data;
    apbRead(a, data);
    checkValue("PRDATA", expData, data, 1);
  endtask

  // Every register goes through the compare process
  task automatic readAll();
    logic [31:0] data;
    apbRead(regCfg0, data);
    apbRead(regCfg1, data);
    for (int r = 0; r < numRegions; r++) begin
      apbRead(regAddrBase + 8'(4 * r), data);
    end
    apbRead(regFaultCount, data);
  endtask

  task automatic accessExpect(input logic [31:0] a, input logic [1:0] kind,
                              input logic [1:0] priv, input logic expSquash);
    @(negedge clk);
    accAddr = a;
    accKind = kind;
    accPriv = priv;
    @(posedge clk);
    checkValue("squash", 32'(expSquash), 32'(squash), 0);
  endtask

  task automatic randomAccess();
    logic [15:0] rnd;
    @(negedge clk);
    rnd = lcgNext();
    accAddr = 32'(rnd[11:0]);
    rnd = lcgNext();
    accKind = rnd[1:0];
    case (rnd[3:2])
      2'd0:    accPriv = privU;
      2'd1:    accPriv = privS;
      default: accPriv = privM;
    endcase
  endtask

  // Small word addresses so that regions overlap the access range
  task automatic randomSetup();
    logic [15:0] rnd;
    logic [31:0] cfgWord [2];
    for (int r = 0; r < numRegions; r++) begin
      rnd = lcgNext();
      apbWrite(regAddrBase + 8'(4 * r), 32'(rnd[9:0]));
    end
    for (int r = 0; r < numRegions; r++) begin
      rnd = lcgNext();
      // Lock bit in about one byte of four
      cfgWord[r / 4][8*(r % 4) +: 8] = {(rnd[9:8] == 2'd0), 2'b00, rnd[4:0]};
    end
    apbWrite(regCfg0, cfgWord[0]);
    apbWrite(regCfg1, cfgWord[1]);
  endtask

  task automatic doReset();
    @(negedge clk);
    reset   = 1'b1;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    accKind = accNone;
    for (int r = 0; r < numRegions; r++) begin
      shadowCfg[r]  = '0;
      shadowAddr[r] = '0;
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    errCount    = '{0, 0, 0};
    lcgState    = 32'd58;
    shadowCount = '0;
    reset       = 1'b1;
    PSEL        = 1'b0;
    PENABLE     = 1'b0;
    PWRITE      = 1'b0;
    PADDR       = '0;
    PWDATA      = '0;
    accAddr     = '0;
    accKind     = accNone;
    accPriv     = privU;
    doReset();

    // Registers are zero and nothing faults after reset
    readAll();
    repeat (30) randomAccess();

    // Readback, then region 1 locked TOR and region 2 locked NA4
    apbWrite(regAddrBase, 32'h100);
    apbWrite(regAddrBase + 8'd4, 32'h200);
    apbWrite(regAddrBase + 8'd8, 32'h300);
    apbWrite(regAddrBase + 8'd16, 32'hFFFFFFFF);
    apbWrite(regCfg1, 32'h1B0B0901);
    apbWrite(regCfg0, 32'h0093891F);
    readExpect(regAddrBase + 8'd16, 32'h3FFFFFFF);
    readExpect(regCfg1, 32'h1B0B0901);
    apbWrite(regAddrBase, 32'h555);
    apbWrite(regAddrBase + 8'd4, 32'h666);
    apbWrite(regAddrBase + 8'd8, 32'h777);
    apbWrite(regAddrBase + 8'd12, 32'h888);
    apbWrite(regCfg0, 32'h0F0F0F0F);
    readExpect(regCfg0, 32'h0F93890F);
    readExpect(regAddrBase, 32'h100);
    readExpect(regAddrBase + 8'd4, 32'h200);
    readExpect(regAddrBase + 8'd8, 32'h300);
    readExpect(regAddrBase + 8'd12, 32'h888);
    repeat (20) randomAccess();

    // Random region setups, 300 accesses in all
    repeat (6) begin
      doReset();
      randomSetup();
      repeat (50) randomAccess();
    end

    // NA4 read-only word inside a NAPOT RWX block of 64 bytes
    doReset();
    apbWrite(regAddrBase, 32'h40);
    apbWrite(regAddrBase + 8'd4, 32'h47);
    apbWrite(regCfg0, 32'h00001F11);
    accessExpect(32'h100, accStore, privS, 1'b1);
    accessExpect(32'h100, accLoad, privS, 1'b0);
    accessExpect(32'h104, accStore, privS, 1'b0);
    accessExpect(32'h140, accLoad, privU, 1'b1);
    accessExpect(32'h100, accStore, privM, 1'b0);

    // Fault counter over five denied loads
    doReset();
    apbWrite(regAddrBase, 32'h80);
    apbWrite(regCfg0, 32'h00000010);
    repeat (5) accessExpect(32'h200, accLoad, privS, 1'b1);
    accessExpect(32'h0, accNone, privS, 1'b0);
    readExpect(regFaultCount, 32'd5);
    // Clear while faulting, one more faulted cycle passes before idle
    accessExpect(32'h200, accLoad, privS, 1'b1);
    apbWrite(regFaultCount, 32'h0);
    accessExpect(32'h0, accNone, privS, 1'b0);
    readExpect(regFaultCount, 32'd1);
    apbWrite(regFaultCount, 32'h0);
    readExpect(regFaultCount, 32'd0);

    // Unmapped and unaligned addresses leave every register alone
    apbWrite(regAddrBase + 8'd12, 32'h123);
    apbWrite(8'h34, 32'hFFFFFFFF);
    apbWrite(regAddrBase + 8'd13, 32'hFFFFFFFF);
    apbWrite(regCfg0 + 8'd2, 32'hFFFFFFFF);
    readExpect(8'h40, 32'h0);
    readExpect(regAddrBase + 8'd12, 32'h123);
    readAll();

    @(negedge clk);
    $display("Errors: fault=%0d read=%0d bus=%0d", errCount[0], errCount[1], errCount[2]);
    if (errCount[0] + errCount[1] + errCount[2] == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: pmpUnit.f
+incdir+include
source/pmpPkg.sv
source/apbSlaveFsm.sv
source/pmpRegFile.sv
source/pmpAdrDec.sv
source/pmpChecker.sv
source/faultCounter.sv
source/pmpUnit.sv
tests/pmpUnitTb.sv

// File: Makefile
# Verilator build and run of the PMP unit testbench

VERILATOR ?= verilator
TOP       ?= pmpUnitTb
FILELIST  ?= pmpUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard source/*.sv) $(wildcard tests/*.sv) $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The run passes only when the log holds the pass line
run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
